// ==== files.f ====
src/fetch_pkg.sv
src/pre_if_stage.sv
src/itlb.sv
src/icache.sv
src/if_stage.sv
src/fetch_top.sv
verification/fetch_mem_model.sv
verification/fetch_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = fetch_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/fetch_tb.sv ====
module fetch_tb import fetch_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        ACT_RUN,
        ACT_BRANCH,
        ACT_FLUSH,
        ACT_ERET,
        ACT_HOLD
    } action_t;

    // flag means no new miss on a branch, a pending refill on a flush and an added flush on an eret
    typedef struct packed {
        action_t    action;
        word_t      operand;
        logic [7:0] count;
        word_t      first_pc; // zero continues the running stream
        logic       flag;
    } entry_t;

    typedef struct packed {
        fs_to_ds_t   bus;
        logic [31:0] reqs; // mem_req count when the item was taken
    } item_t;

    localparam int NUM_ENTRIES = 12;
    localparam int WAIT_LIMIT  = 200;

    logic      clk;
    logic      reset;
    br_bus_t   br_bus;
    logic      flush;
    word_t     epc;
    logic      eret;
    logic      ds_allowin;
    fs_to_ds_t fs_to_ds;
    logic      fs_to_ds_valid;
    logic      mem_req;
    word_t     mem_addr;
    logic      mem_rvalid;
    word_t     mem_rdata;

    entry_t      table_q [NUM_ENTRIES];
    item_t       got_q [$];
    logic [31:0] req_count;
    logic [31:0] req_snap;
    word_t       exp_pc;
    int          errors;
    logic        abort;

    fetch_top #(
        .NUM_SETS (256)
    ) fetch_top_i (
        .clk            (clk),
        .reset          (reset),
        .br_bus         (br_bus),
        .flush          (flush),
        .epc            (epc),
        .eret           (eret),
        .ds_allowin     (ds_allowin),
        .fs_to_ds       (fs_to_ds),
        .fs_to_ds_valid (fs_to_ds_valid),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_rvalid     (mem_rvalid),
        .mem_rdata      (mem_rdata)
    );

    fetch_mem_model mem_i (
        .clk        (clk),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    always #2 clk = ~clk;

    // items taken by decode sampled mid-cycle
    always @(negedge clk) begin
        item_t it;
        if (reset) begin
            req_count = 32'd0;
        end else begin
            if (mem_req)
                req_count = req_count + 32'd1;
            if (fs_to_ds_valid && ds_allowin) begin
                it = {fs_to_ds, req_count};
                got_q.push_back(it);
            end
        end
    end

    // kseg0/kseg1 drop the top three bits
    function automatic word_t phys_addr(word_t va);
        if (va[31:30] == 2'b10)
            return {3'b000, va[28:0]};
        return va;
    endfunction

    task automatic check_item(item_t it, word_t pc, logic bdd, logic ex);
        word_t    inst;
        exccode_t code;
        inst = ex ? 32'd0 : phys_addr(pc) ^ 32'h5a5a_0000;
        code = ex ? EXC_ADEL : EXC_NONE;
        if (it.bus.pc !== pc) begin
            errors++;
            $display("Error: fs_to_ds.pc got %h exp %h", it.bus.pc, pc);
        end
        if (it.bus.inst !== inst) begin
            errors++;
            $display("Error: fs_to_ds.inst got %h exp %h (pc %h)", it.bus.inst, inst, pc);
        end
        if (it.bus.bdd !== bdd) begin
            errors++;
            $display("Error: fs_to_ds.bdd got %h exp %h (pc %h)", it.bus.bdd, bdd, pc);
        end
        if (it.bus.ex !== ex) begin
            errors++;
            $display("Error: fs_to_ds.ex got %h exp %h (pc %h)", it.bus.ex, ex, pc);
        end
        if (it.bus.exccode !== code) begin
            errors++;
            $display("Error: fs_to_ds.exccode got %h exp %h (pc %h)", it.bus.exccode, code, pc);
        end
    endtask

    task automatic pop_item(output item_t it);
        int n;
        n  = 0;
        it = '0;
        while (got_q.size() == 0 && n < WAIT_LIMIT && !abort) begin
            @(posedge clk);
            n++;
        end
        if (got_q.size() == 0) begin
            if (!abort) begin
                errors++;
                $display("timeout waiting for an instruction, expected pc %h", exp_pc);
            end
            abort = 1'b1;
        end else begin
            it = got_q.pop_front();
        end
    endtask

    task automatic expect_run(int n);
        item_t it;
        for (int i = 0; i < n; i++) begin
            pop_item(it);
            if (abort)
                return;
            check_item(it, exp_pc, 1'b0, 1'b0);
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    // items fetched before a redirect still arrive in order
    task automatic drain_old(word_t stop_pc, output item_t it);
        int n;
        n = 0;
        pop_item(it);
        while (!abort && it.bus.pc != stop_pc && n < 64) begin
            check_item(it, exp_pc, 1'b0, 1'b0);
            exp_pc = exp_pc + 32'd4;
            n++;
            pop_item(it);
        end
        if (!abort && it.bus.pc != stop_pc) begin
            errors++;
            $display("no instruction at pc %h within 64 deliveries", stop_pc);
            abort = 1'b1;
        end
    endtask

    task automatic do_branch(entry_t e);
        item_t it;
        word_t bdd_pc;
        logic  issued;
        int    n;
        issued = 1'b0;
        bdd_pc = '0;
        n      = 0;
        @(posedge clk);
        #1;
        br_bus = '{stall: 1'b0, taken: 1'b1, target: e.operand};
        // keep taken until a fetch goes out alongside it
        while (!issued && n < WAIT_LIMIT) begin
            #2;
            if (fetch_top_i.inst_valid) begin
                issued = 1'b1;
                bdd_pc = fetch_top_i.ps_to_fs.pc;
            end
            @(posedge clk);
            #1;
            n++;
        end
        br_bus.taken = 1'b0;
        if (!issued) begin
            errors++;
            $display("timeout waiting to issue the delay slot for branch to %h", e.operand);
            abort = 1'b1;
            return;
        end
        drain_old(bdd_pc, it);
        if (abort)
            return;
        check_item(it, exp_pc, 1'b1, 1'b0);
        req_snap = it.reqs;
        exp_pc   = e.first_pc;
        if (e.first_pc[1:0] != 2'b00) begin
            pop_item(it);
            if (abort)
                return;
            check_item(it, exp_pc, 1'b0, 1'b1); // fetch stalls until a redirect
        end else begin
            for (int i = 0; i < int'(e.count); i++) begin
                pop_item(it);
                if (abort)
                    return;
                check_item(it, exp_pc, 1'b0, 1'b0);
                exp_pc = exp_pc + 32'd4;
            end
        end
        if (e.flag && it.reqs != req_snap) begin
            errors++;
            $display("memory read issued after branch to %h, expected none", e.operand);
        end
    endtask

    task automatic wait_refill();
        int n;
        n = 0;
        @(negedge clk);
        while (!mem_req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!mem_req) begin
            errors++;
            $display("timeout waiting for a cache refill");
            abort = 1'b1;
        end
    endtask

    task automatic do_redirect(entry_t e);
        item_t it;
        if (e.action == ACT_FLUSH && e.flag)
            wait_refill();
        if (abort)
            return;
        @(posedge clk);
        #1;
        if (e.action == ACT_FLUSH) begin
            flush = 1'b1;
        end else begin
            eret  = 1'b1;
            epc   = e.operand;
            flush = e.flag;
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
        eret  = 1'b0;
        drain_old(e.first_pc, it);
        if (abort)
            return;
        exp_pc = e.first_pc;
        check_item(it, exp_pc, 1'b0, 1'b0);
        exp_pc = exp_pc + 32'd4;
        expect_run(int'(e.count) - 1);
    endtask

    task automatic do_hold(entry_t e);
        fs_to_ds_t held;
        int        n;
        n = 0;
        @(posedge clk);
        #1;
        // stall decode in a cycle that presents an item
        while (!fs_to_ds_valid && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!fs_to_ds_valid) begin
            errors++;
            $display("timeout waiting for an instruction to hold");
            abort = 1'b1;
            return;
        end
        held       = fs_to_ds;
        ds_allowin = 1'b0;
        repeat (e.count) begin
            #2;
            if (!fs_to_ds_valid) begin
                errors++;
                $display("held instruction at pc %h dropped while decode stalled", held.pc);
            end else if (fs_to_ds !== held) begin
                errors++;
                $display("Error: fs_to_ds got %h exp %h", fs_to_ds, held);
            end
            @(posedge clk);
            #1;
        end
        ds_allowin = 1'b1;
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        br_bus     = '0;
        flush      = 1'b0;
        epc        = '0;
        eret       = 1'b0;
        ds_allowin = 1'b1;
        errors     = 0;
        abort      = 1'b0;
        exp_pc     = RESET_PC;
        req_snap   = 32'd0;

        table_q[0]  = '{ACT_RUN,    32'h0,         8'd24, RESET_PC,      1'b0};
        table_q[1]  = '{ACT_BRANCH, 32'hbfc0_0000, 8'd16, 32'hbfc0_0000, 1'b1}; // loop hits
        table_q[2]  = '{ACT_HOLD,   32'h0,         8'd6,  32'h0,         1'b0};
        table_q[3]  = '{ACT_RUN,    32'h0,         8'd8,  32'h0,         1'b0};
        table_q[4]  = '{ACT_FLUSH,  32'h0,         8'd6,  GENERAL_EX_PC, 1'b0};
        table_q[5]  = '{ACT_FLUSH,  32'h0,         8'd6,  GENERAL_EX_PC, 1'b1}; // during refill
        table_q[6]  = '{ACT_ERET,   32'hbfc0_1000, 8'd8,  32'hbfc0_1000, 1'b1}; // eret beats flush
        table_q[7]  = '{ACT_BRANCH, 32'hbfc0_0102, 8'd1,  32'hbfc0_0102, 1'b1}; // AdEL
        table_q[8]  = '{ACT_ERET,   32'h8000_1000, 8'd8,  32'h8000_1000, 1'b0};
        table_q[9]  = '{ACT_HOLD,   32'h0,         8'd5,  32'h0,         1'b0};
        table_q[10] = '{ACT_RUN,    32'h0,         8'd4,  32'h0,         1'b0};
        table_q[11] = '{ACT_BRANCH, 32'h8000_1000, 8'd8,  32'h8000_1000, 1'b1};

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!abort) begin
                case (table_q[i].action)
                    ACT_RUN: begin
                        if (table_q[i].first_pc != 32'h0)
                            exp_pc = table_q[i].first_pc;
                        expect_run(int'(table_q[i].count));
                    end
                    ACT_BRANCH: do_branch(table_q[i]);
                    ACT_HOLD:   do_hold(table_q[i]);
                    default:    do_redirect(table_q[i]);
                endcase
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== verification/fetch_mem_model.sv ====
module fetch_mem_model import fetch_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  mem_req,
    input  word_t mem_addr,
    output logic  mem_rvalid,
    output word_t mem_rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    word_t       base;
    int unsigned gap;

    // one line per request as four words in address order with random gaps
    initial begin
        void'($urandom(97));
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (!reset && mem_req) begin
                base = mem_addr;
                for (int i = 0; i < 4; i++) begin
                    gap = $urandom_range(3, 0);
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                        mem_rvalid = 1'b0;
                    end
                    @(posedge clk);
                    #1;
                    mem_rvalid = 1'b1;
                    mem_rdata  = (base + 32'(i * 4)) ^ 32'h5a5a_0000; // address-derived word
                end
                @(posedge clk);
                #1;
                mem_rvalid = 1'b0;
            end
        end
    end

endmodule

// ==== src/fetch_top.sv ====
module fetch_top import fetch_pkg::*; #(
    parameter int NUM_SETS = 256
) (
    input  logic      clk,
    input  logic      reset,
    input  br_bus_t   br_bus,
    input  logic      flush,
    input  word_t     epc,
    input  logic      eret,
    input  logic      ds_allowin,
    output fs_to_ds_t fs_to_ds,
    output logic      fs_to_ds_valid,
    output logic      mem_req,
    output word_t     mem_addr,
    input  logic      mem_rvalid,
    input  word_t     mem_rdata
);

    ps_to_fs_t    ps_to_fs;
    logic         ps_to_fs_valid;
    logic         fs_allowin;
    logic         icache_busy;
    set_index_t   inst_index;
    pfn_t         inst_tag;
    line_offset_t inst_offset;
    vpn_t         inst_vpn;
    pfn_t         inst_pfn;
    logic         inst_valid;
    word_t        inst_rdata;
    logic         inst_rvalid;

    pre_if_stage pre_if_stage_i (
        .clk            (clk),
        .reset          (reset),
        .fs_allowin     (fs_allowin),
        .br_bus         (br_bus),
        .flush          (flush),
        .epc            (epc),
        .eret           (eret),
        .icache_busy    (icache_busy),
        .inst_pfn       (inst_pfn),
        .ps_to_fs       (ps_to_fs),
        .ps_to_fs_valid (ps_to_fs_valid),
        .inst_index     (inst_index),
        .inst_tag       (inst_tag),
        .inst_offset    (inst_offset),
        .inst_vpn       (inst_vpn),
        .inst_valid     (inst_valid)
    );

    itlb itlb_i (
        .vpn (inst_vpn),
        .pfn (inst_pfn)
    );

    icache #(
        .NUM_SETS (NUM_SETS)
    ) icache_i (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst_index  (inst_index),
        .inst_tag    (inst_tag),
        .inst_offset (inst_offset),
        .icache_busy (icache_busy),
        .inst_rdata  (inst_rdata),
        .inst_rvalid (inst_rvalid),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    if_stage if_stage_i (
        .clk            (clk),
        .reset          (reset),
        .ps_to_fs       (ps_to_fs),
        .ps_to_fs_valid (ps_to_fs_valid),
        .inst_valid     (inst_valid),
        .inst_rdata     (inst_rdata),
        .inst_rvalid    (inst_rvalid),
        .ds_allowin     (ds_allowin),
        .fs_allowin     (fs_allowin),
        .fs_to_ds       (fs_to_ds),
        .fs_to_ds_valid (fs_to_ds_valid)
    );

endmodule

// ==== src/if_stage.sv ====
module if_stage import fetch_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  ps_to_fs_t ps_to_fs,
    input  logic      ps_to_fs_valid,
    input  logic      inst_valid,
    input  word_t     inst_rdata,
    input  logic      inst_rvalid,
    input  logic      ds_allowin,
    output logic      fs_allowin,
    output fs_to_ds_t fs_to_ds,
    output logic      fs_to_ds_valid
);

    ps_to_fs_t pend;       // bus of the last request sent out
    logic      ex_valid;   // AdEL item, due one cycle after capture
    logic      capture;
    logic      live_valid;
    fs_to_ds_t live_bus;
    logic      hold_valid; // decode stalled on a delivered item
    fs_to_ds_t hold_bus;

    assign capture = ps_to_fs_valid & (inst_valid | ps_to_fs.ex);

    always_ff @(posedge clk) begin
        if (capture)
            pend <= ps_to_fs;
    end

    always_ff @(posedge clk) begin
        if (reset)
            ex_valid <= 1'b0;
        else
            ex_valid <= ps_to_fs_valid & ps_to_fs.ex;
    end

    assign live_valid = inst_rvalid | ex_valid;

    always_comb begin
        live_bus.pc      = pend.pc;
        live_bus.inst    = pend.inst_valid ? inst_rdata : '0; // no fetch on AdEL
        live_bus.bdd     = pend.bdd;
        live_bus.ex      = pend.ex;
        live_bus.exccode = pend.exccode;
    end

    always_ff @(posedge clk) begin
        if (reset)
            hold_valid <= 1'b0;
        else if (live_valid & ~ds_allowin & ~hold_valid)
            hold_valid <= 1'b1;
        else if (ds_allowin)
            hold_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (live_valid & ~hold_valid)
            hold_bus <= live_bus;
    end

    assign fs_to_ds       = hold_valid ? hold_bus : live_bus;
    assign fs_to_ds_valid = hold_valid | live_valid;

    // a new request returns next cycle at the earliest, so only block
    // while something is stuck in front of decode
    assign fs_allowin = ds_allowin | ~(hold_valid | live_valid);

endmodule

// ==== src/icache.sv ====
module icache import fetch_pkg::*; #(
    parameter int NUM_SETS = 256
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         inst_valid,
    input  set_index_t   inst_index,
    input  pfn_t         inst_tag,
    input  line_offset_t inst_offset,
    output logic         icache_busy,
    output word_t        inst_rdata,
    output logic         inst_rvalid,
    output logic         mem_req,
    output word_t        mem_addr,
    input  logic         mem_rvalid,
    input  word_t        mem_rdata
);

    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int LINE_W = $bits(pfn_t) + $bits(set_index_t); // pa[31:4]
    localparam int TAG_W  = LINE_W - IDX_W;

    icache_state_t state;

    logic [LINE_W-1:0] line_addr;
    logic [IDX_W-1:0]  set;
    logic [TAG_W-1:0]  tag;

    // the request being refilled
    logic [LINE_W-1:0] req_line;
    logic [IDX_W-1:0]  req_set;
    logic [TAG_W-1:0]  req_tag;
    logic [1:0]        req_word;
    logic [1:0]        refill_cnt;

    logic [TAG_W-1:0]  tag_arr [NUM_SETS];
    word_t             data_arr [NUM_SETS][4];
    logic [NUM_SETS-1:0] valid_arr;

    logic lookup;
    logic accept;
    logic hit;
    logic last_word;

    assign line_addr = {inst_tag, inst_index};
    assign set       = line_addr[IDX_W-1:0];
    assign tag       = line_addr[LINE_W-1:IDX_W];
    assign req_set   = req_line[IDX_W-1:0];
    assign req_tag   = req_line[LINE_W-1:IDX_W];

    assign lookup    = state != REFILL; // DONE takes new requests too
    assign accept    = inst_valid & lookup;
    assign hit       = valid_arr[set] & (tag_arr[set] == tag);
    assign last_word = mem_rvalid & (refill_cnt == 2'd3);

    assign icache_busy = state == REFILL;
    assign mem_addr    = {req_line, 4'b0000};

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            inst_rvalid <= 1'b0;
            mem_req     <= 1'b0;
            refill_cnt  <= 2'd0;
            valid_arr   <= '0;
        end else begin
            inst_rvalid <= 1'b0;
            mem_req     <= 1'b0;
            case (state)
                IDLE, DONE: begin
                    state <= IDLE;
                    if (accept) begin
                        req_line <= line_addr;
                        req_word <= inst_offset[3:2];
                        if (hit) begin
                            inst_rvalid <= 1'b1;
                        end else begin
                            state      <= REFILL;
                            mem_req    <= 1'b1; // one strobe per line
                            refill_cnt <= 2'd0;
                        end
                    end
                end
                REFILL: begin
                    if (mem_rvalid)
                        refill_cnt <= refill_cnt + 2'd1;
                    if (last_word) begin
                        state              <= DONE;
                        inst_rvalid        <= 1'b1;
                        valid_arr[req_set] <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // arrays and read data
    always_ff @(posedge clk) begin
        if (accept & hit)
            inst_rdata <= data_arr[set][inst_offset[3:2]];
        if (icache_busy & mem_rvalid) begin
            data_arr[req_set][refill_cnt] <= mem_rdata;
            if (refill_cnt == req_word)
                inst_rdata <= mem_rdata; // critical word, answer without a reread
            if (refill_cnt == 2'd3)
                tag_arr[req_set] <= req_tag;
        end
    end

    a_no_stray_rvalid: assert property (
        @(posedge clk) disable iff (reset) state == IDLE |-> !mem_rvalid
    ) else $error("refill word returned with no refill pending");

endmodule

// ==== src/itlb.sv ====
module itlb import fetch_pkg::*; (
    input  vpn_t vpn,
    output pfn_t pfn
);

    logic unmapped_seg; // kseg0 or kseg1

    // va 0x8000_0000..0xbfff_ffff has va[31:30] == 2'b10
    assign unmapped_seg = vpn[19:18] == 2'b10;

    // strip va[31:29], useg and kseg2/3 go through as is
    always_comb begin
        if (unmapped_seg)
            pfn = {3'b000, vpn[16:0]};
        else
            pfn = vpn;
    end

endmodule

// ==== src/pre_if_stage.sv ====
module pre_if_stage import fetch_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         fs_allowin,
    input  br_bus_t      br_bus,
    input  logic         flush,
    input  word_t        epc,
    input  logic         eret,
    input  logic         icache_busy,
    input  pfn_t         inst_pfn,
    output ps_to_fs_t    ps_to_fs,
    output logic         ps_to_fs_valid,
    output set_index_t   inst_index,
    output pfn_t         inst_tag,
    output line_offset_t inst_offset,
    output vpn_t         inst_vpn,
    output logic         inst_valid
);

    word_t prefs_pc;
    word_t next_pc;
    word_t seq_pc;
    logic  flush_delayed; // redirect seen and first fetch at new pc not yet issued
    logic  ex_hold;       // AdEL already sent so wait for the handler redirect
    logic  redirect;
    logic  misaligned;
    logic  take_branch;
    logic  advance;
    logic  issue;
    logic  ps_ex;
    logic  pc_we;

    assign redirect   = flush | eret;
    assign misaligned = prefs_pc[1:0] != 2'b00;

    // a branch still sitting in decode after a flush is stale
    assign take_branch = br_bus.taken & ~flush_delayed;

    assign advance = ~icache_busy & fs_allowin & ~br_bus.stall & ~ex_hold;
    assign issue   = advance & ~redirect; // nothing goes out in a redirect cycle
    assign ps_ex   = issue & misaligned;
    assign pc_we   = redirect | (advance & ~misaligned);

    assign seq_pc = prefs_pc + 32'd4;

    // eret > flush > branch > sequential
    always_comb begin
        if (eret)
            next_pc = epc;
        else if (flush)
            next_pc = GENERAL_EX_PC;
        else if (take_branch)
            next_pc = br_bus.target;
        else
            next_pc = seq_pc;
    end

    always_ff @(posedge clk) begin
        if (reset)
            prefs_pc <= RESET_PC;
        else if (pc_we)
            prefs_pc <= next_pc;
    end

    // flush during a refill is kept until the new pc actually issues
    always_ff @(posedge clk) begin
        if (reset)
            flush_delayed <= 1'b0;
        else if (redirect)
            flush_delayed <= 1'b1;
        else if (advance)
            flush_delayed <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            ex_hold <= 1'b0;
        else if (redirect)
            ex_hold <= 1'b0;
        else if (ps_ex)
            ex_hold <= 1'b1;
    end

    assign inst_valid = issue & ~misaligned;

    assign ps_to_fs_valid      = ~icache_busy;
    assign ps_to_fs.inst_valid = inst_valid;
    assign ps_to_fs.bdd        = take_branch; // issued while the branch resolves
    assign ps_to_fs.pc         = prefs_pc;
    assign ps_to_fs.ex         = ps_ex;
    assign ps_to_fs.exccode    = ps_ex ? EXC_ADEL : EXC_NONE;

    assign inst_vpn    = prefs_pc[31:12];
    assign inst_tag    = inst_pfn;
    assign inst_index  = prefs_pc[11:4];
    assign inst_offset = prefs_pc[3:0];

    // a misaligned pc holds and sends no cache request until a redirect
    a_no_misaligned_req: assert property (
        @(posedge clk) disable iff (reset)
        misaligned & ~redirect |=> ~inst_valid & $stable(prefs_pc)
    ) else $error("misaligned pc %h moved or reached the cache", prefs_pc);

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // plain vector types
    typedef logic [31:0] word_t;
    typedef logic [19:0] vpn_t;         // va[31:12]
    typedef logic [19:0] pfn_t;         // pa[31:12]
    typedef logic [7:0]  set_index_t;   // addr[11:4]
    typedef logic [3:0]  line_offset_t; // byte within a 16-byte line
    typedef logic [4:0]  exccode_t;

    localparam exccode_t EXC_NONE = 5'd0;
    localparam exccode_t EXC_ADEL = 5'd4; // address error on fetch

    // boot vector and general exception entry, both in kseg1
    localparam word_t RESET_PC      = 32'hbfc0_0000;
    localparam word_t GENERAL_EX_PC = 32'hbfc0_0380;

    // branch result from decode
    typedef struct packed {
        logic  stall;  // decode waiting on an operand
        logic  taken;
        word_t target;
    } br_bus_t;

    // pre-fetch to fetch stage
    typedef struct packed {
        logic     inst_valid; // a cache request went out for this pc
        logic     bdd;        // branch delay slot
        word_t    pc;
        logic     ex;
        exccode_t exccode;
    } ps_to_fs_t;

    // fetch stage to decode
    typedef struct packed {
        word_t    pc;
        word_t    inst;
        logic     bdd;
        logic     ex;
        exccode_t exccode;
    } fs_to_ds_t;

    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        DONE
    } icache_state_t;

endpackage
